// File: src/vec_fmt_pkg.sv
// Fixed-point vector number format

package vec_fmt_pkg;

    // Signed Q16.16 components
    localparam int WORD_BITS = 32;
    localparam int FRAC_BITS = 16;
    localparam int VEC_LEN   = 3;

    // Full product width before rescaling
    localparam int PROD_BITS = 2 * WORD_BITS;

    typedef logic signed [WORD_BITS-1:0] word_t;
    typedef logic signed [PROD_BITS-1:0] prod_t;

    // Component 0 sits in the lowest word
    typedef word_t [VEC_LEN-1:0] vec_t;

    // Dot product result, scalar in the lowest word
    typedef struct packed {
        word_t zero_hi;
        word_t zero_mid;
        word_t scalar;
    } scalar_view_t;

    // Same three words, read as a vector or as a scalar
    typedef union packed {
        vec_t         vec;
        scalar_view_t dot;
    } result_t;

endpackage

// File: src/vec_op_pkg.sv
// Vector unit commands

package vec_op_pkg;

    localparam int OP_BITS = 3;

    // Result buffer entries
    localparam int FIFO_DEPTH = 16;

    typedef enum logic [OP_BITS-1:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_DOT   = 3'd2,
        OP_CROSS = 3'd3,
        OP_SCALE = 3'd4
    } vec_op_e;

    typedef struct packed {
        vec_op_e          op;
        vec_fmt_pkg::vec_t x;
        vec_fmt_pkg::vec_t y;
    } command_t;

endpackage

// File: src/vec_stream_if.sv
// Valid/ready stream between stages

`timescale 1ns/1ps

interface vec_stream_if #(
    parameter type payload_t = logic
) ();

    // Transfer on a rising edge with valid and ready both high
    logic     valid;
    logic     ready;
    payload_t data;

    // Data held stable while stalled
    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: src/operand_fetch.sv
// Command fetch from input FIFO

`timescale 1ns/1ps

module operand_fetch (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_empty,
    output logic                  in_rd_en,
    input  vec_op_pkg::vec_op_e   in_op,
    input  vec_fmt_pkg::vec_t     in_x,
    input  vec_fmt_pkg::vec_t     in_y,
    vec_stream_if.source          cmd
);

    logic                 cmd_full;
    logic                 has_room;
    vec_op_pkg::command_t cmd_reg;

    // Room when empty or when the held command leaves this cycle
    assign has_room = ~cmd_full | cmd.ready;

    // Pop on the same edge that captures the operands
    assign in_rd_en = ~in_empty & has_room;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_full <= 1'b0;
        end else if (has_room) begin
            cmd_full <= ~in_empty;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            cmd_reg.op <= in_op;
            cmd_reg.x  <= in_x;
            cmd_reg.y  <= in_y;
        end
    end

    assign cmd.valid = cmd_full;
    assign cmd.data  = cmd_reg;

endmodule

// File: src/vector_alu.sv
// Fixed-point vector ALU

`timescale 1ns/1ps

module vector_alu (
    input  logic         clock,
    input  logic         reset,
    vec_stream_if.sink   cmd,
    vec_stream_if.source res
);

    logic                 accept;
    logic                 res_full;
    vec_fmt_pkg::vec_t    op_x;
    vec_fmt_pkg::vec_t    op_y;
    vec_fmt_pkg::result_t result_c;
    vec_fmt_pkg::result_t result_reg;

    // Double-width signed product of two components
    function automatic vec_fmt_pkg::prod_t mul_full(
        input vec_fmt_pkg::word_t a,
        input vec_fmt_pkg::word_t b
    );
        vec_fmt_pkg::prod_t wide_a;
        vec_fmt_pkg::prod_t wide_b;
        wide_a = a;
        wide_b = b;
        return wide_a * wide_b;
    endfunction

    // Back to Q16.16, rounds toward minus infinity
    function automatic vec_fmt_pkg::word_t fx_word(
        input vec_fmt_pkg::prod_t p
    );
        vec_fmt_pkg::prod_t shifted;
        shifted = p >>> vec_fmt_pkg::FRAC_BITS;
        return shifted[vec_fmt_pkg::WORD_BITS-1:0];
    endfunction

    assign op_x = cmd.data.x;
    assign op_y = cmd.data.y;

    always_comb begin
        result_c.vec = '0;
        case (cmd.data.op)
            vec_op_pkg::OP_ADD: begin
                for (int i = 0; i < vec_fmt_pkg::VEC_LEN; i++) begin
                    result_c.vec[i] = op_x[i] + op_y[i];
                end
            end
            vec_op_pkg::OP_SUB: begin
                for (int i = 0; i < vec_fmt_pkg::VEC_LEN; i++) begin
                    result_c.vec[i] = op_x[i] - op_y[i];
                end
            end
            vec_op_pkg::OP_DOT: begin
                // Each product rescaled before the sum
                result_c.dot.zero_hi  = '0;
                result_c.dot.zero_mid = '0;
                result_c.dot.scalar   = fx_word(mul_full(op_x[0], op_y[0]))
                                      + fx_word(mul_full(op_x[1], op_y[1]))
                                      + fx_word(mul_full(op_x[2], op_y[2]));
            end
            vec_op_pkg::OP_CROSS: begin
                // Difference taken at full width, then rescaled
                result_c.vec[0] = fx_word(mul_full(op_x[1], op_y[2])
                                        - mul_full(op_x[2], op_y[1]));
                result_c.vec[1] = fx_word(mul_full(op_x[2], op_y[0])
                                        - mul_full(op_x[0], op_y[2]));
                result_c.vec[2] = fx_word(mul_full(op_x[0], op_y[1])
                                        - mul_full(op_x[1], op_y[0]));
            end
            vec_op_pkg::OP_SCALE: begin
                // Factor is y component 0
                for (int i = 0; i < vec_fmt_pkg::VEC_LEN; i++) begin
                    result_c.vec[i] = fx_word(mul_full(op_x[i], op_y[0]));
                end
            end
            default: begin
                result_c.vec = '0;
            end
        endcase
    end

    // One-deep output stage
    assign accept    = ~res_full | res.ready;
    assign cmd.ready = accept;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            res_full <= 1'b0;
        end else if (accept) begin
            res_full <= cmd.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && cmd.valid) begin
            result_reg <= result_c;
        end
    end

    assign res.valid = res_full;
    assign res.data  = result_reg;

endmodule

// File: src/result_fifo.sv
// Result FIFO, first word fall through

`timescale 1ns/1ps

module result_fifo (
    input  logic                  clock,
    input  logic                  reset,
    vec_stream_if.sink            wr,
    output logic                  out_empty,
    input  logic                  out_rd_en,
    output vec_fmt_pkg::result_t  out_result
);

    vec_fmt_pkg::result_t mem [vec_op_pkg::FIFO_DEPTH];

    logic [$clog2(vec_op_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(vec_op_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(vec_op_pkg::FIFO_DEPTH+1)-1:0] count;
    logic [$clog2(vec_op_pkg::FIFO_DEPTH+1)-1:0] avail;
    logic                                        full;
    logic                                        do_wr;
    logic                                        do_rd;
    logic                                        wr_seen;

    assign full     = (count == vec_op_pkg::FIFO_DEPTH);
    assign wr.ready = ~full;
    assign do_wr    = wr.valid & ~full;

    // Read while empty is ignored
    assign out_empty = (avail == 0);
    assign do_rd     = out_rd_en & ~out_empty;

    assign out_result = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            avail   <= '0;
            wr_seen <= 1'b0;
        end else begin
            wr_seen <= do_wr;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Stored entries, for the full flag
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (!do_wr && do_rd) begin
                count <= count - 1'b1;
            end
            // Readable entries lag a write by one cycle
            if (wr_seen && !do_rd) begin
                avail <= avail + 1'b1;
            end else if (!wr_seen && do_rd) begin
                avail <= avail - 1'b1;
            end
        end
    end

endmodule

// File: src/vec_unit_top.sv
// Vector unit top level

`timescale 1ns/1ps

module vec_unit_top (
    input  logic                  clock,
    input  logic                  reset,

    // Command FIFO side
    input  logic                  in_empty,
    output logic                  in_rd_en,
    input  vec_op_pkg::vec_op_e   in_op,
    input  vec_fmt_pkg::vec_t     in_x,
    input  vec_fmt_pkg::vec_t     in_y,

    // Result side
    output logic                  out_empty,
    input  logic                  out_rd_en,
    output vec_fmt_pkg::result_t  out_result
);

    vec_stream_if #(
        .payload_t (vec_op_pkg::command_t)
    ) cmd_bus ();

    vec_stream_if #(
        .payload_t (vec_fmt_pkg::result_t)
    ) res_bus ();

    operand_fetch u_operand_fetch (
        .clock    (clock),
        .reset    (reset),
        .in_empty (in_empty),
        .in_rd_en (in_rd_en),
        .in_op    (in_op),
        .in_x     (in_x),
        .in_y     (in_y),
        .cmd      (cmd_bus.source)
    );

    vector_alu u_vector_alu (
        .clock (clock),
        .reset (reset),
        .cmd   (cmd_bus.sink),
        .res   (res_bus.source)
    );

    result_fifo u_result_fifo (
        .clock      (clock),
        .reset      (reset),
        .wr         (res_bus.sink),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en),
        .out_result (out_result)
    );

endmodule

// File: dv/vec_unit_tb.sv
// Vector unit testbench

`timescale 1ns/1ps

module vec_unit_tb;

    localparam int WAIT_LIMIT  = 2000;
    localparam int HOLD_CYCLES = 20;
    localparam int HELD_MAX    = 18;
    localparam int RD_HOLD     = 0;
    localparam int RD_ALWAYS   = 1;
    localparam int RD_RANDOM   = 2;

    logic                 clock     = 1'b0;
    logic                 reset;
    logic                 in_empty  = 1'b1;
    logic                 in_rd_en;
    vec_op_pkg::vec_op_e  in_op     = vec_op_pkg::OP_ADD;
    vec_fmt_pkg::vec_t    in_x      = '0;
    vec_fmt_pkg::vec_t    in_y      = '0;
    logic                 out_empty;
    logic                 out_rd_en = 1'b0;
    vec_fmt_pkg::result_t out_result;

    // Stimulus table with expected values worked out by hand
    vec_op_pkg::vec_op_e row_op[$];
    vec_fmt_pkg::vec_t   row_x[$];
    vec_fmt_pkg::vec_t   row_y[$];
    vec_fmt_pkg::vec_t   row_exp[$];

    // Row order seen through the input FIFO model
    int          stim_seq[$];
    int          stim_limit = 0;
    int          in_ptr     = 0;
    int          out_ptr    = 0;
    int          pops       = 0;
    int          pop_cycle  = 0;
    int          cycle      = 0;
    int          rd_mode    = RD_HOLD;
    int          checks     = 0;
    int          errors     = 0;
    logic [15:0] lfsr       = 16'd39;

    vec_unit_top DUT (
        .clock      (clock),
        .reset      (reset),
        .in_empty   (in_empty),
        .in_rd_en   (in_rd_en),
        .in_op      (in_op),
        .in_x       (in_x),
        .in_y       (in_y),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en),
        .out_result (out_result)
    );

    always #2 clock = ~clock;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    function automatic vec_fmt_pkg::vec_t vec3(
        input vec_fmt_pkg::word_t c0,
        input vec_fmt_pkg::word_t c1,
        input vec_fmt_pkg::word_t c2
    );
        return {c2, c1, c0};
    endfunction

    task automatic add_row(
        input vec_op_pkg::vec_op_e op,
        input vec_fmt_pkg::vec_t   x,
        input vec_fmt_pkg::vec_t   y,
        input vec_fmt_pkg::vec_t   expected
    );
        row_op.push_back(op);
        row_x.push_back(x);
        row_y.push_back(y);
        row_exp.push_back(expected);
    endtask

    task automatic load_table();
        add_row(vec_op_pkg::OP_ADD, vec3(32'h0001_0000, 32'h0002_0000, 32'hFFFD_0000),
                vec3(32'h0000_8000, 32'hFFFD_8000, 32'h0001_4000),
                vec3(32'h0001_8000, 32'hFFFF_8000, 32'hFFFE_4000));
        add_row(vec_op_pkg::OP_ADD, vec3(32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0003),
                vec3(32'h0000_0001, 32'hFFFF_FFFF, 32'hFFFF_FFFE),
                vec3(32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001));
        add_row(vec_op_pkg::OP_SUB, vec3(32'h0001_0000, 32'hFFFF_0000, 32'h0003_8000),
                vec3(32'h0002_0000, 32'h0000_4000, 32'hFFFF_8000),
                vec3(32'hFFFF_0000, 32'hFFFE_C000, 32'h0004_0000));
        add_row(vec_op_pkg::OP_SUB, vec3(32'h8000_0000, 32'h0000_0000, 32'h7FFF_FFFF),
                vec3(32'h0000_0001, 32'h0000_0001, 32'hFFFF_FFFF),
                vec3(32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000));
        // Scale ignores y components 1 and 2
        add_row(vec_op_pkg::OP_SCALE, vec3(32'h0001_8000, 32'hFFFE_0000, 32'h0000_4000),
                vec3(32'h0002_0000, 32'h1234_5678, 32'h9ABC_DEF0),
                vec3(32'h0003_0000, 32'hFFFC_0000, 32'h0000_8000));
        add_row(vec_op_pkg::OP_SCALE, vec3(32'hFFFF_FFFF, 32'h0000_0003, 32'h0001_0000),
                vec3(32'h0000_8000, 32'h0000_0000, 32'h0000_0000),
                vec3(32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_8000));
        // 100.0 times 1000.0 wraps past the word
        add_row(vec_op_pkg::OP_SCALE, vec3(32'h0064_0000, 32'hFF9C_0000, 32'h0000_0000),
                vec3(32'h03E8_0000, 32'h0000_0000, 32'h0000_0000),
                vec3(32'h86A0_0000, 32'h7960_0000, 32'h0000_0000));
        add_row(vec_op_pkg::OP_DOT, vec3(32'h0001_0000, 32'h0002_0000, 32'h0003_0000),
                vec3(32'h0004_0000, 32'hFFFB_0000, 32'h0000_8000),
                vec3(32'hFFFB_8000, 32'h0000_0000, 32'h0000_0000));
        // Each product floors on its own before the sum
        add_row(vec_op_pkg::OP_DOT, vec3(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001),
                vec3(32'h0000_8000, 32'h0000_8000, 32'h0000_8000),
                vec3(32'hFFFF_FFFE, 32'h0000_0000, 32'h0000_0000));
        add_row(vec_op_pkg::OP_CROSS, vec3(32'h0001_0000, 32'h0000_0000, 32'h0000_0000),
                vec3(32'h0000_0000, 32'h0001_0000, 32'h0000_0000),
                vec3(32'h0000_0000, 32'h0000_0000, 32'h0001_0000));
        add_row(vec_op_pkg::OP_CROSS, vec3(32'h0001_0000, 32'h0002_0000, 32'h0003_0000),
                vec3(32'h0004_0000, 32'h0005_0000, 32'h0006_0000),
                vec3(32'hFFFD_0000, 32'h0006_0000, 32'hFFFD_0000));
        add_row(vec_op_pkg::OP_CROSS, vec3(32'h0000_0000, 32'h0000_8000, 32'h0000_0000),
                vec3(32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF),
                vec3(32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000));
        add_row(vec_op_pkg::OP_CROSS, vec3(32'h0000_8000, 32'h0000_C000, 32'h0000_0000),
                vec3(32'h0001_8000, 32'hFFFF_0000, 32'h0000_0000),
                vec3(32'h0000_0000, 32'h0000_0000, 32'hFFFE_6000));
    endtask

    task automatic queue_rows(input int passes);
        for (int p = 0; p < passes; p++) begin
            for (int r = 0; r < row_op.size(); r++) begin
                stim_seq.push_back(r);
            end
        end
        stim_limit = stim_seq.size();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_pops(input int target, input string what);
        int n;
        n = 0;
        while (pops < target && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (pops < target) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_results(input int target, input string what);
        int n;
        n = 0;
        while (out_ptr < target && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (out_ptr < target) begin
            report_timeout(what);
        end
    endtask

    task automatic check_idle(input string when_text);
        checks++;
        assert (!in_rd_en && out_empty) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s, in_rd_en=%b out_empty=%b",
                     $time, when_text, in_rd_en, out_empty);
        end
    endtask

    task automatic check_result(input int row);
        vec_fmt_pkg::vec_t expected;
        expected = row_exp[row];
        checks++;
        if (row_op[row] == vec_op_pkg::OP_DOT) begin
            // Scalar view with upper words zero
            assert (out_result.dot.scalar == expected[0] && out_result.dot.zero_mid == '0
                    && out_result.dot.zero_hi == '0) else begin
                errors++;
                $display("CHECK FAILED at %0t: result %0d row %0d dot got %h expected %h",
                         $time, out_ptr, row, out_result, expected);
            end
        end else begin
            assert (out_result.vec == expected) else begin
                errors++;
                $display("CHECK FAILED at %0t: result %0d row %0d got %h expected %h",
                         $time, out_ptr, row, out_result.vec, expected);
            end
        end
    endtask

    // Pops and reads sampled on the rising edge
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (!reset && !in_empty && in_rd_en) begin
            in_ptr    <= in_ptr + 1;
            pops      <= pops + 1;
            pop_cycle <= cycle + 1;
        end
        if (!reset && !out_empty && out_rd_en) begin
            assert (out_ptr < stim_seq.size()) else begin
                errors++;
                $display("Result read at %0t with no command outstanding", $time);
            end
            if (out_ptr < stim_seq.size()) begin
                check_result(stim_seq[out_ptr]);
            end
            out_ptr <= out_ptr + 1;
        end
    end

    // Input FIFO model and output reader
    always @(negedge clock) begin
        if (in_ptr < stim_limit) begin
            in_empty <= 1'b0;
            in_op    <= row_op[stim_seq[in_ptr]];
            in_x     <= row_x[stim_seq[in_ptr]];
            in_y     <= row_y[stim_seq[in_ptr]];
        end else begin
            in_empty <= 1'b1;
        end
        case (rd_mode)
            RD_ALWAYS: out_rd_en <= 1'b1;
            RD_RANDOM: begin
                out_rd_en <= lfsr[0];
                lfsr      <= lfsr_next(lfsr);
            end
            default: out_rd_en <= 1'b0;
        endcase
    end

    initial begin
        int n;
        int base;
        reset = 1'b1;
        load_table();
        repeat (16) begin
            @(negedge clock);
            check_idle("during reset");
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clock);
            check_idle("after reset");
        end

        // Idle pipeline latency for one command
        @(posedge clock);
        stim_seq.push_back(7);
        stim_limit = stim_seq.size();
        wait_pops(1, "latency command pop");
        n = 0;
        while (out_empty && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (out_empty) begin
            report_timeout("latency result");
        end else begin
            checks++;
            assert (cycle - pop_cycle == 3) else begin
                errors++;
                $display("CHECK FAILED at %0t: out_empty fell %0d cycles after pop, expected 3",
                         $time, cycle - pop_cycle);
            end
        end
        @(posedge clock);
        rd_mode = RD_ALWAYS;
        wait_results(stim_seq.size(), "latency result read");

        // Whole table at full rate
        queue_rows(1);
        wait_results(stim_seq.size(), "full rate results");

        // Output stalled until the pipeline fills up
        rd_mode = RD_HOLD;
        base = pops;
        queue_rows(2);
        wait_pops(base + HELD_MAX, "pops with output stalled");
        repeat (HOLD_CYCLES) begin
            @(posedge clock);
            checks++;
            assert (in_empty || !in_rd_en) else begin
                errors++;
                $display("CHECK FAILED at %0t: in_rd_en high with result FIFO full", $time);
            end
        end
        checks++;
        assert (pops - base == HELD_MAX) else begin
            errors++;
            $display("CHECK FAILED at %0t: %0d commands popped while stalled, expected %0d",
                     $time, pops - base, HELD_MAX);
        end
        rd_mode = RD_ALWAYS;
        wait_results(stim_seq.size(), "results after stall");

        // Random output back-pressure
        rd_mode = RD_RANDOM;
        queue_rows(3);
        wait_results(stim_seq.size(), "results under random reads");

        rd_mode = RD_ALWAYS;
        repeat (8) @(posedge clock);
        checks++;
        assert (out_empty && out_ptr == stim_seq.size()) else begin
            errors++;
            $display("Extra results found after all commands were read");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/vec_fmt_pkg.sv
src/vec_op_pkg.sv
src/vec_stream_if.sv
src/operand_fetch.sv
src/vector_alu.sv
src/result_fifo.sv
src/vec_unit_top.sv
dv/vec_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the vector unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module vec_unit_tb -o vec_unit_sim > build.log 2>&1 \
    && ./obj_dir/vec_unit_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run error"; exit 1; }

cat sim.log

grep -q "Simulation failed" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
